//--- mips_pkg.sv
// ==============================
// Shared sizes, encodings and bus types for the MIPS subset core
// Memory is word addressed, so byte address bits [1:0] are dropped
// ==============================
package mips_pkg;

  localparam int          mem_words = 1024;
  localparam int          addr_w    = 10;
  localparam logic [31:0] reset_pc  = 32'h0000_0000;

  // Primary opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_jal   = 6'h03;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_slti  = 6'h0a;
  localparam logic [5:0] op_andi  = 6'h0c;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lui   = 6'h0f;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  // Function codes under op_rtype
  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_srl  = 6'h02;
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_xor  = 6'h26;
  localparam logic [5:0] fn_nor  = 6'h27;
  localparam logic [5:0] fn_slt  = 6'h2a;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_view_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_view_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } j_view_t;

  // One instruction word, three field layouts
  typedef union packed {
    r_view_t r;
    i_view_t i;
    j_view_t j;
  } instr_u;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_nor, alu_slt, alu_sll, alu_srl, alu_lui
  } alu_op_e;

  typedef struct packed {
    logic              en;     // Held until gnt
    logic              we;
    logic [addr_w-1:0] addr;   // Word address
    logic [31:0]       wdata;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
  } retire_t;

endpackage

//--- unified_mem.sv
// ==============================
// Single-port word memory, no reset on contents
// Read data valid the cycle after the request, write lands at the edge
// ==============================
`timescale 1ns/1ps

module unified_mem (
  input  logic               clk,
  input  mips_pkg::mem_req_t req,
  output logic [31:0]        rdata
);

  logic [31:0] mem [mips_pkg::mem_words];

  always_ff @(posedge clk) begin
    if (req.en) begin
      if (req.we) begin
        mem[req.addr] <= req.wdata;
      end else begin
        rdata <= mem[req.addr];  // Held until the next read
      end
    end
  end

  // Address width covers every word, so only an unknown address misses
  a_addr_range: assert property (
    @(posedge clk) req.en |-> !$isunknown(req.addr)
  );

endmodule

//--- mem_arbiter.sv
// ==============================
// Fixed priority host > data > fetch, one grant per cycle
// Grant is combinational, rvalid follows a read grant by one cycle
// ==============================
`timescale 1ns/1ps

module mem_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  mips_pkg::mem_req_t host_req,
  input  mips_pkg::mem_req_t data_req,
  input  mips_pkg::mem_req_t fetch_req,
  output logic               host_gnt,
  output logic               data_gnt,
  output logic               fetch_gnt,
  output logic               host_rvalid,
  output logic               data_rvalid,
  output logic               fetch_rvalid,
  output mips_pkg::mem_req_t mem_req
);

  logic [2:0] rd_owner;  // {host, data, fetch} read granted last cycle

  always_comb begin
    host_gnt  = host_req.en;
    data_gnt  = data_req.en && !host_req.en;
    fetch_gnt = fetch_req.en && !host_req.en && !data_req.en;

    if (host_gnt) begin
      mem_req = host_req;
    end else if (data_gnt) begin
      mem_req = data_req;
    end else if (fetch_gnt) begin
      mem_req = fetch_req;
    end else begin
      mem_req = '0;  // Idle memory
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_owner <= '0;
    end else begin
      rd_owner <= {host_gnt, data_gnt, fetch_gnt} & {3{!mem_req.we}};
    end
  end

  assign host_rvalid  = rd_owner[2];
  assign data_rvalid  = rd_owner[1];
  assign fetch_rvalid = rd_owner[0];

  // A requester left waiting keeps the same request
  a_data_hold: assert property (
    @(posedge clk) disable iff (rst)
      (data_req.en && !data_gnt) |=> (data_req.en && $stable(data_req))
  );

  a_fetch_hold: assert property (
    @(posedge clk) disable iff (rst)
      (fetch_req.en && !fetch_gnt) |=> (fetch_req.en && $stable(fetch_req))
  );

endmodule

//--- fetch_unit.sv
// ==============================
// PC, one-entry prefetch buffer, at most one read outstanding
// Redirect flushes the buffer; an older return in flight is dropped
// ==============================
`timescale 1ns/1ps

module fetch_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  output mips_pkg::mem_req_t fetch_req,
  input  logic               fetch_gnt,
  input  logic               fetch_rvalid,
  input  logic [31:0]        rdata,
  output logic               ifetch_valid,
  output mips_pkg::instr_u   ifetch_instr,
  output logic [31:0]        ifetch_pc,
  input  logic               ifetch_take,
  input  logic               redirect,
  input  logic [31:0]        redirect_pc
);

  logic [31:0] pc;          // Next fetch address
  logic [31:0] pend_pc;     // Address of the read in flight
  logic [31:0] fetch_addr;
  logic        pending;
  logic        stale;       // Return belongs to a flushed path
  logic        waiting;     // Raised last cycle, no grant yet

  // A redirect fetches its target in the same cycle
  assign fetch_addr = redirect ? redirect_pc : pc;

  always_comb begin
    fetch_req      = '0;
    fetch_req.en   = waiting || (run && !pending && (!ifetch_valid || ifetch_take));
    fetch_req.addr = fetch_addr[mips_pkg::addr_w+1:2];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= mips_pkg::reset_pc;
      pending      <= 1'b0;
      stale        <= 1'b0;
      waiting      <= 1'b0;
      ifetch_valid <= 1'b0;
    end else begin
      waiting <= fetch_req.en && !fetch_gnt;

      if (fetch_gnt) begin
        pc <= fetch_addr + 32'd4;
      end else if (redirect) begin
        pc <= redirect_pc;
      end

      if (fetch_gnt) begin
        pending <= 1'b1;
      end else if (fetch_rvalid) begin
        pending <= 1'b0;
      end

      if (fetch_rvalid) begin
        stale <= 1'b0;
      end else if (redirect && pending) begin
        stale <= 1'b1;
      end

      if (redirect) begin
        ifetch_valid <= 1'b0;
      end else if (fetch_rvalid && !stale) begin
        ifetch_valid <= 1'b1;
      end else if (ifetch_take) begin
        ifetch_valid <= 1'b0;
      end
    end

    if (fetch_gnt) pend_pc <= fetch_addr;
    if (fetch_rvalid) begin
      ifetch_instr <= rdata;
      ifetch_pc    <= pend_pc;
    end
  end

  a_no_overrun: assert property (
    @(posedge clk) disable iff (rst) fetch_rvalid |-> !ifetch_valid
  );

endmodule

//--- reg_file.sv
// ==============================
// 32 x 32 registers, async read, write at the clock edge
// Register 0 reads zero and ignores writes
// ==============================
`timescale 1ns/1ps

module reg_file (
  input  logic        clk,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  output logic [31:0] rd1,
  output logic [31:0] rd2,
  input  logic        we,
  input  logic [4:0]  wa,
  input  logic [31:0] wd
);

  logic [31:0] regs [32];

  assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

  always_ff @(posedge clk) begin
    if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

endmodule

//--- alu.sv
// ==============================
// Combinational ALU, shifts act on b by shamt
// slt compares signed, lui places b[15:0] in the upper half
// ==============================
`timescale 1ns/1ps

module alu (
  input  mips_pkg::alu_op_e op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  input  logic [4:0]        shamt,
  output logic [31:0]       result,
  output logic              zero
);

  always_comb begin
    case (op)
      mips_pkg::alu_add: result = a + b;
      mips_pkg::alu_sub: result = a - b;
      mips_pkg::alu_and: result = a & b;
      mips_pkg::alu_or:  result = a | b;
      mips_pkg::alu_xor: result = a ^ b;
      mips_pkg::alu_nor: result = ~(a | b);
      mips_pkg::alu_slt: result = {31'd0, $signed(a) < $signed(b)};
      mips_pkg::alu_sll: result = b << shamt;
      mips_pkg::alu_srl: result = b >> shamt;  // Logical
      mips_pkg::alu_lui: result = {b[15:0], 16'h0000};
      default:           result = 32'd0;
    endcase
  end

  assign zero = (result == 32'd0);  // Branch compare

endmodule

//--- exec_unit.sv
// ==============================
// Decode, execute and write back, one instruction at a time
// Loads and stores wait on the data port; no delay slots
// ==============================
`timescale 1ns/1ps

module exec_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  logic               ifetch_valid,
  input  mips_pkg::instr_u   ifetch_instr,
  input  logic [31:0]        ifetch_pc,
  output logic               ifetch_take,
  output logic               redirect,
  output logic [31:0]        redirect_pc,
  output mips_pkg::mem_req_t data_req,
  input  logic               data_gnt,
  input  logic               data_rvalid,
  input  logic [31:0]        rdata,
  output mips_pkg::retire_t  retire
);

  typedef enum logic [1:0] {st_idle, st_mem, st_load} state_e;
  typedef enum logic [1:0] {dst_rt, dst_rd, dst_ra} dst_e;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_e;

  typedef struct packed {
    mips_pkg::alu_op_e alu_op;
    logic              imm_src;
    logic              zext;    // andi, ori
    dst_e              dst;
    wb_e               wb;
    logic              reg_we;
    logic              is_sw;
    logic              is_beq;
    logic              is_bne;
    logic              is_j;
    logic              is_jr;
  } ctrl_t;

  state_e           state;
  ctrl_t            ctrl;
  mips_pkg::instr_u ins;
  logic [31:0]      rs_val;
  logic [31:0]      rt_val;
  logic [31:0]      ext_imm;
  logic [31:0]      alu_b;
  logic [31:0]      alu_y;
  logic             alu_zero;
  logic [31:0]      pc4;
  logic [4:0]       dst_reg;
  logic             mem_op;
  logic             rf_we;
  logic [4:0]       rf_wa;
  logic [31:0]      rf_wd;
  logic             retire_fire;
  logic [31:0]      mem_pc;    // Load or store waiting on the port
  logic [4:0]       mem_rd;
  logic             ret_load;  // Current retire is a load

  assign ins = ifetch_instr;

  always_comb begin
    ctrl = '0;
    case (ins.r.opcode)
      mips_pkg::op_rtype: begin
        ctrl.dst    = dst_rd;
        ctrl.reg_we = 1'b1;
        case (ins.r.funct)
          mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
          mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
          mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
          mips_pkg::fn_nor:  ctrl.alu_op = mips_pkg::alu_nor;
          mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
          mips_pkg::fn_srl:  ctrl.alu_op = mips_pkg::alu_srl;
          mips_pkg::fn_jr: begin
            ctrl.reg_we = 1'b0;
            ctrl.is_jr  = 1'b1;
          end
          default: ctrl.reg_we = 1'b0;  // Unsupported funct acts as nop
        endcase
      end
      mips_pkg::op_addiu,
      mips_pkg::op_slti,
      mips_pkg::op_andi,
      mips_pkg::op_ori,
      mips_pkg::op_lui: begin
        ctrl.imm_src = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.zext    = ins.r.opcode inside {mips_pkg::op_andi, mips_pkg::op_ori};
        case (ins.r.opcode)
          mips_pkg::op_slti: ctrl.alu_op = mips_pkg::alu_slt;
          mips_pkg::op_andi: ctrl.alu_op = mips_pkg::alu_and;
          mips_pkg::op_ori:  ctrl.alu_op = mips_pkg::alu_or;
          mips_pkg::op_lui:  ctrl.alu_op = mips_pkg::alu_lui;
          default:           ctrl.alu_op = mips_pkg::alu_add;
        endcase
      end
      mips_pkg::op_lw: begin
        ctrl.imm_src = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.wb      = wb_mem;
      end
      mips_pkg::op_sw: begin
        ctrl.imm_src = 1'b1;
        ctrl.is_sw   = 1'b1;
      end
      mips_pkg::op_beq: begin
        ctrl.alu_op = mips_pkg::alu_sub;
        ctrl.is_beq = 1'b1;
      end
      mips_pkg::op_bne: begin
        ctrl.alu_op = mips_pkg::alu_sub;
        ctrl.is_bne = 1'b1;
      end
      mips_pkg::op_j: ctrl.is_j = 1'b1;
      mips_pkg::op_jal: begin
        ctrl.is_j   = 1'b1;
        ctrl.reg_we = 1'b1;
        ctrl.dst    = dst_ra;
        ctrl.wb     = wb_link;
      end
      default: ctrl.wb = wb_alu;  // Unknown opcode, no effect
    endcase
  end

  reg_file u_reg_file (
    .clk,
    .ra1 (ins.r.rs),
    .ra2 (ins.r.rt),
    .rd1 (rs_val),
    .rd2 (rt_val),
    .we  (rf_we),
    .wa  (rf_wa),
    .wd  (rf_wd)
  );

  assign ext_imm = ctrl.zext ? {16'h0000, ins.i.imm} : {{16{ins.i.imm[15]}}, ins.i.imm};
  assign alu_b   = ctrl.imm_src ? ext_imm : rt_val;

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs_val),
    .b      (alu_b),
    .shamt  (ins.r.shamt),
    .result (alu_y),
    .zero   (alu_zero)
  );

  always_comb begin
    case (ctrl.dst)
      dst_rt:  dst_reg = ins.i.rt;
      dst_rd:  dst_reg = ins.r.rd;
      default: dst_reg = 5'd31;
    endcase
  end

  assign pc4         = ifetch_pc + 32'd4;
  assign mem_op      = (ctrl.wb == wb_mem) || ctrl.is_sw;
  assign ifetch_take = run && ifetch_valid && (state == st_idle);
  assign redirect    = ifetch_take && (ctrl.is_j || ctrl.is_jr ||
                       (ctrl.is_beq && alu_zero) || (ctrl.is_bne && !alu_zero));

  always_comb begin
    if (ctrl.is_jr) begin
      redirect_pc = rs_val;
    end else if (ctrl.is_j) begin
      redirect_pc = {pc4[31:28], ins.j.target, 2'b00};
    end else begin
      redirect_pc = pc4 + {{14{ins.i.imm[15]}}, ins.i.imm, 2'b00};
    end
  end

  // Single write port shared by take-time results and load returns
  assign rf_we = (ifetch_take && ctrl.reg_we && ctrl.wb != wb_mem) ||
                 (state == st_load && data_rvalid);
  assign rf_wa = (state == st_idle) ? dst_reg : mem_rd;
  assign rf_wd = (state != st_idle) ? rdata : (ctrl.wb == wb_link) ? pc4 : alu_y;

  assign retire_fire = (ifetch_take && !mem_op) ||
                       (state == st_mem && data_gnt && data_req.we) ||
                       (state == st_load && data_rvalid);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_idle;
      data_req.en  <= 1'b0;
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= retire_fire;
      case (state)
        st_idle: begin
          if (ifetch_take && mem_op) begin
            state       <= st_mem;
            data_req.en <= 1'b1;
          end
        end
        st_mem: begin
          if (data_gnt) begin
            data_req.en <= 1'b0;
            state       <= data_req.we ? st_idle : st_load;  // sw done at grant
          end
        end
        default: begin
          if (data_rvalid) state <= st_idle;
        end
      endcase
    end

    if (ifetch_take && mem_op) begin
      data_req.we    <= ctrl.is_sw;
      data_req.addr  <= alu_y[mips_pkg::addr_w+1:2];
      data_req.wdata <= rt_val;
      mem_pc         <= ifetch_pc;
      mem_rd         <= dst_reg;
    end

    if (retire_fire) begin
      retire.pc   <= (state == st_idle) ? ifetch_pc : mem_pc;
      retire.we   <= rf_we;
      retire.rd   <= rf_we ? rf_wa : 5'd0;
      retire.data <= rf_we ? rf_wd : 32'd0;
      ret_load    <= (state == st_load);
    end
  end

  // A load spends at least a grant and a return on the data port
  a_load_gap: assert property (
    @(posedge clk) disable iff (rst) (retire.valid && ret_load) |-> !$past(retire.valid)
  );

endmodule

//--- mips_top.sv
// ==============================
// Core, arbiter and shared memory
// Host port has top priority and should be used with run low
// ==============================
`timescale 1ns/1ps

module mips_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  mips_pkg::mem_req_t host_req,
  output logic               host_gnt,
  output logic               host_rvalid,
  output logic [31:0]        host_rdata,
  output mips_pkg::retire_t  retire
);

  mips_pkg::mem_req_t data_req;
  mips_pkg::mem_req_t fetch_req;
  mips_pkg::mem_req_t mem_req;
  mips_pkg::instr_u   ifetch_instr;
  logic               data_gnt;
  logic               data_rvalid;
  logic               fetch_gnt;
  logic               fetch_rvalid;
  logic [31:0]        mem_rdata;
  logic               ifetch_valid;
  logic               ifetch_take;
  logic [31:0]        ifetch_pc;
  logic               redirect;
  logic [31:0]        redirect_pc;

  assign host_rdata = mem_rdata;  // Shared read bus

  unified_mem u_mem (
    .clk,
    .req   (mem_req),
    .rdata (mem_rdata)
  );

  mem_arbiter u_arbiter (
    .clk, .rst,
    .host_req, .data_req, .fetch_req,
    .host_gnt, .data_gnt, .fetch_gnt,
    .host_rvalid, .data_rvalid, .fetch_rvalid,
    .mem_req
  );

  fetch_unit u_fetch (
    .clk, .rst, .run,
    .fetch_req, .fetch_gnt, .fetch_rvalid,
    .rdata (mem_rdata),
    .ifetch_valid, .ifetch_instr, .ifetch_pc, .ifetch_take,
    .redirect, .redirect_pc
  );

  exec_unit u_exec (
    .clk, .rst, .run,
    .ifetch_valid, .ifetch_instr, .ifetch_pc, .ifetch_take,
    .redirect, .redirect_pc,
    .data_req, .data_gnt, .data_rvalid,
    .rdata (mem_rdata),
    .retire
  );

endmodule

//--- tb_checker.sv
// ==============================
// Reference model and scoreboard for mips_top
// Model memory is built from granted host writes
// Host accesses are expected only while the core is stopped
// ==============================
`timescale 1ns/1ps

module tb_checker (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  mips_pkg::mem_req_t host_req,
  input  logic               host_gnt,
  input  logic               host_rvalid,
  input  logic [31:0]        host_rdata,
  input  mips_pkg::retire_t  retire,
  output int                 retire_errs,
  output int                 mem_errs,
  output int                 retired,
  output int                 reads
);

  logic [31:0]                 mem [mips_pkg::mem_words];
  logic [31:0]                 regs [32];
  logic [31:0]                 pc;       // Model pc of the next retire
  logic [mips_pkg::addr_w-1:0] rd_addr;  // Host read in flight
  logic                        started;

  task automatic check_field(input string field, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      retire_errs++;
      $display("mismatch %0t: retire %s at pc %h got %h expected %h",
               $time, field, pc, got, exp);
    end
  endtask

  // Executes the instruction at the model pc and compares the retire record
  task automatic step_model();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic [31:0] res;
    logic [4:0]  dst;
    logic        wr;
    ins     = mem[pc[mips_pkg::addr_w+1:2]];
    a       = regs[ins[25:21]];
    b       = regs[ins[20:16]];
    simm    = {{16{ins[15]}}, ins[15:0]};
    addr    = a + simm;
    next_pc = pc + 32'd4;
    res     = '0;
    dst     = ins[20:16];
    wr      = 1'b1;
    case (ins[31:26])
      mips_pkg::op_rtype: begin
        dst = ins[15:11];
        case (ins[5:0])
          mips_pkg::fn_addu: res = a + b;
          mips_pkg::fn_subu: res = a - b;
          mips_pkg::fn_and:  res = a & b;
          mips_pkg::fn_or:   res = a | b;
          mips_pkg::fn_xor:  res = a ^ b;
          mips_pkg::fn_nor:  res = ~(a | b);
          mips_pkg::fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mips_pkg::fn_sll:  res = b << ins[10:6];
          mips_pkg::fn_srl:  res = b >> ins[10:6];
          mips_pkg::fn_jr: begin
            wr      = 1'b0;
            next_pc = a;
          end
          default: wr = 1'b0;
        endcase
      end
      mips_pkg::op_addiu: res = a + simm;
      mips_pkg::op_slti:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
      mips_pkg::op_andi:  res = a & {16'h0000, ins[15:0]};
      mips_pkg::op_ori:   res = a | {16'h0000, ins[15:0]};
      mips_pkg::op_lui:   res = {ins[15:0], 16'h0000};
      mips_pkg::op_lw:    res = mem[addr[mips_pkg::addr_w+1:2]];
      mips_pkg::op_sw: begin
        wr = 1'b0;
        mem[addr[mips_pkg::addr_w+1:2]] = b;
      end
      mips_pkg::op_beq: begin
        wr = 1'b0;
        if (a == b) next_pc = pc + 32'd4 + (simm << 2);
      end
      mips_pkg::op_bne: begin
        wr = 1'b0;
        if (a != b) next_pc = pc + 32'd4 + (simm << 2);
      end
      mips_pkg::op_j: begin
        wr      = 1'b0;
        next_pc = {next_pc[31:28], ins[25:0], 2'b00};
      end
      mips_pkg::op_jal: begin
        dst     = 5'd31;
        res     = pc + 32'd4;  // No delay slot
        next_pc = {next_pc[31:28], ins[25:0], 2'b00};
      end
      default: wr = 1'b0;
    endcase
    check_field("pc", retire.pc, pc);
    check_field("we", 32'(retire.we), 32'(wr));
    check_field("rd", 32'(retire.rd), wr ? 32'(dst) : 32'd0);
    check_field("data", retire.data, wr ? res : 32'd0);
    if (wr && dst != 5'd0) regs[dst] = res;
    pc = next_pc;
    retired++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pc          = mips_pkg::reset_pc;
      regs[0]     = 32'd0;  // r0 reads zero
      started     = 1'b0;
      retire_errs = 0;
      mem_errs    = 0;
      retired     = 0;
      reads       = 0;
    end else begin
      if (retire.valid) begin
        if (!started) begin
          retire_errs++;
          $display("mismatch %0t: retire valid before run was raised", $time);
        end
        step_model();
      end
      if (run) started = 1'b1;
      if (host_rvalid) begin
        reads++;
        if (host_rdata !== mem[rd_addr]) begin
          mem_errs++;
          $display("mismatch %0t: readback word %0d got %h expected %h",
                   $time, rd_addr, host_rdata, mem[rd_addr]);
        end
      end
      if (host_req.en && host_gnt) begin
        if (host_req.we) mem[host_req.addr] = host_req.wdata;
        else rd_addr = host_req.addr;
      end
    end
  end

endmodule

//--- tb_mips.sv
// ==============================
// Random program testbench for mips_top
// Program and data are loaded through the host port with run low
// Registers r2..r9 are preset, r1 holds the data region base
// ==============================
`timescale 1ns/1ps

module tb_mips;

  localparam logic [31:0] seed       = 32'hc71c61c8;
  localparam int          prog_len   = 96;
  localparam int          data_base  = 256;  // Word address, byte 0x400
  localparam int          data_words = 32;
  localparam int          jal_slot   = 40;
  localparam int          sub_slot   = 89;   // Subroutine, returns with jr
  localparam int          end_slot   = 95;   // Jumps to itself
  localparam int          limit_cycles = prog_len * 20 + (prog_len + data_words) * 2
                                         + data_words * 3 + 200;

  logic               clk;
  logic               rst;
  logic               run;
  mips_pkg::mem_req_t host_req;
  logic               host_gnt;
  logic               host_rvalid;
  logic [31:0]        host_rdata;
  mips_pkg::retire_t  retire;

  logic [31:0] lfsr;
  logic [31:0] prog [prog_len];
  logic [31:0] init_data [data_words];
  int          other_errs;
  int          retire_errs;
  int          mem_errs;
  int          retired;
  int          reads;
  int          pause;

  mips_top u_mips_top (
    .clk, .rst, .run,
    .host_req, .host_gnt, .host_rvalid, .host_rdata,
    .retire
  );

  tb_checker u_checker (
    .clk, .rst, .run,
    .host_req, .host_gnt, .host_rvalid, .host_rdata,
    .retire,
    .retire_errs, .mem_errs, .retired, .reads
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [4:0] pick_reg();
    return 5'd2 + 5'(take_bits(3));  // r2..r9
  endfunction

  function automatic logic [31:0] gen_alu();
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [5:0] code;
    rs = pick_reg();
    rt = pick_reg();
    rd = pick_reg();
    if (take_bits(1) == 32'd1) begin
      case (take_bits(4) % 32'd9)
        32'd0:   code = mips_pkg::fn_addu;
        32'd1:   code = mips_pkg::fn_subu;
        32'd2:   code = mips_pkg::fn_and;
        32'd3:   code = mips_pkg::fn_or;
        32'd4:   code = mips_pkg::fn_xor;
        32'd5:   code = mips_pkg::fn_nor;
        32'd6:   code = mips_pkg::fn_sll;
        32'd7:   code = mips_pkg::fn_srl;
        default: code = mips_pkg::fn_slt;
      endcase
      return {mips_pkg::op_rtype, rs, rt, rd, 5'(take_bits(5)), code};
    end
    case (take_bits(3) % 32'd5)
      32'd0:   code = mips_pkg::op_addiu;
      32'd1:   code = mips_pkg::op_slti;
      32'd2:   code = mips_pkg::op_andi;
      32'd3:   code = mips_pkg::op_ori;
      default: code = mips_pkg::op_lui;
    endcase
    return {code, rs, rd, 16'(take_bits(16))};
  endfunction

  // Word-aligned access inside the data region through r1
  function automatic logic [31:0] gen_mem(input logic store);
    logic [4:0] rt;
    logic [4:0] word;
    rt   = pick_reg();
    word = 5'(take_bits(5));
    return {store ? mips_pkg::op_sw : mips_pkg::op_lw, 5'd1, rt, 9'd0, word, 2'b00};
  endfunction

  // Forward only, never past the jal or the jump over the subroutine
  function automatic logic [31:0] gen_flow(input int p, input int kind);
    int         tgt;
    int         bar;
    logic [4:0] rs;
    logic [4:0] rt;
    bar = (p < jal_slot) ? jal_slot : sub_slot - 1;
    tgt = p + 2 + int'(take_bits(2));
    if (tgt > bar) tgt = bar;
    if (kind == 2) return {mips_pkg::op_j, 26'(tgt)};
    rs = pick_reg();
    rt = pick_reg();
    return {(kind == 0) ? mips_pkg::op_beq : mips_pkg::op_bne, rs, rt, 16'(tgt - p - 1)};
  endfunction

  task automatic build_program();
    int sel;
    prog[0] = {mips_pkg::op_lui, 5'd0, 5'd1, 16'h0000};
    prog[1] = {mips_pkg::op_ori, 5'd1, 5'd1, 16'(data_base * 4)};
    for (int r = 0; r < 8; r++) begin
      prog[2 + r] = {mips_pkg::op_addiu, 5'd0, 5'(r + 2), 16'(take_bits(16))};
    end
    for (int p = 10; p < sub_slot - 1; p++) begin
      sel = int'(take_bits(4));
      if (p == jal_slot) prog[p] = {mips_pkg::op_jal, 26'(sub_slot)};
      else if (sel < 9) prog[p] = gen_alu();
      else if (sel < 11) prog[p] = gen_mem(1'b0);
      else if (sel < 13) prog[p] = gen_mem(1'b1);
      else prog[p] = gen_flow(p, sel - 13);
    end
    prog[sub_slot - 1] = {mips_pkg::op_j, 26'(end_slot)};
    for (int p = sub_slot; p < end_slot - 1; p++) begin
      prog[p] = gen_alu();
    end
    prog[end_slot - 1] = {mips_pkg::op_rtype, 5'd31, 15'd0, mips_pkg::fn_jr};
    prog[end_slot]     = {mips_pkg::op_j, 26'(end_slot)};
    for (int i = 0; i < data_words; i++) begin
      init_data[i] = take_bits(32);
    end
  endtask

  // One host transfer, entered 1 ns after a rising edge
  task automatic host_access(input logic we, input logic [mips_pkg::addr_w-1:0] addr,
                             input logic [31:0] wdata);
    int waited;
    waited         = 0;
    host_req.en    = 1'b1;
    host_req.we    = we;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    @(posedge clk);
    while (!host_gnt && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (!host_gnt) begin
      other_errs++;
      $display("Host request to word %0d was never granted", addr);
    end
    #1 host_req = '0;
    if (!we) begin
      @(posedge clk);
      if (!host_rvalid) begin
        other_errs++;
        $display("Host read of word %0d returned no read-valid", addr);
      end
      #1;
    end
  endtask

  task automatic wait_retires(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(posedge clk);
      if (retire.valid) seen++;
    end
  endtask

  task automatic wait_final();
    do begin
      @(posedge clk);
    end while (!(retire.valid && retire.pc == 32'(end_slot * 4)));
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(limit_cycles * 20);
    $display("Timeout: the program did not finish within %0d cycles", limit_cycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    lfsr       = seed;
    rst        = 1'b1;
    run        = 1'b0;
    host_req   = '0;
    other_errs = 0;
    build_program();
    pause = 1 + int'(take_bits(4));
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    for (int a = 0; a < prog_len; a++) begin
      host_access(1'b1, 10'(a), prog[a]);
    end
    for (int a = 0; a < data_words; a++) begin
      host_access(1'b1, 10'(data_base + a), init_data[a]);
    end
    run = 1'b1;
    wait_retires(20);
    #1 run = 1'b0;  // Stall mid-program
    repeat (pause) @(posedge clk);
    #1 run = 1'b1;
    wait_final();
    #1 run = 1'b0;
    repeat (20) @(posedge clk);  // Let in-flight work drain
    #1;
    for (int a = 0; a < data_words; a++) begin
      host_access(1'b0, 10'(data_base + a), 32'd0);
    end
    repeat (4) @(posedge clk);
    if (reads != data_words) begin
      other_errs++;
      $display("Host readback returned %0d of %0d words", reads, data_words);
    end
    if (retired == 0) begin
      other_errs++;
      $display("No instruction retired");
    end
    $display("Errors: retire %0d, memory %0d, other %0d", retire_errs, mem_errs, other_errs);
    if (retire_errs + mem_errs + other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- flist.f
mips_pkg.sv
unified_mem.sv
mem_arbiter.sv
fetch_unit.sv
reg_file.sv
alu.sv
exec_unit.sv
mips_top.sv
tb_checker.sv
tb_mips.sv

//--- Makefile
# Verilator build and run for the MIPS subset core

VERILATOR ?= verilator
TOP       ?= tb_mips
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -o $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
